/* verilog/div_pkg.sv */
package div_pkg;

    // operand and tag widths
    localparam int xlen  = 32;
    localparam int tag_w = 4;

    // RV32M divide opcodes handled by the unit
    typedef enum logic [1:0] {
        op_div  = 2'd0,  // signed quotient
        op_divu = 2'd1,  // unsigned quotient
        op_rem  = 2'd2,  // signed remainder
        op_remu = 2'd3   // unsigned remainder
    } div_op_e;

    // request as seen at the unit boundary
    typedef struct packed {
        div_op_e          op;
        logic [xlen-1:0]  a;    // dividend
        logic [xlen-1:0]  b;    // divisor
        logic [tag_w-1:0] tag;
    } div_req_t;

    // tagged result
    typedef struct packed {
        logic [xlen-1:0]  value;
        logic [tag_w-1:0] tag;
    } div_res_t;

    // lane FSM
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1,  // core iterating
        st_fix  = 2'd2,  // sign fix-up and select
        st_done = 2'd3   // result held until take
    } lane_state_e;

endpackage

/* verilog/div_core.sv */
`timescale 1ns/1ps

module div_core #(
    parameter int width = 32
) (
    input  logic             clk_i,
    input  logic             arst_n,
    input  logic             start,
    input  logic [width-1:0] dividend,
    input  logic [width-1:0] divisor,
    output logic             busy,
    output logic             valid,
    output logic [width-1:0] quotient,
    output logic [width-1:0] remainder
);

    localparam int cnt_w = $clog2(width);
    localparam logic [cnt_w-1:0] last_step = cnt_w'(width - 1);

    logic [width-1:0] dsr;                  // divisor copy
    logic [width-1:0] quo;
    logic [width-1:0] quo_next;
    logic [width:0]   acc;                  // one bit wider than operands
    logic [width:0]   acc_next;
    logic [width:0]   acc_diff;
    logic [cnt_w-1:0] step;

    // one restoring step: subtract if it fits, then shift in the quotient bit
    always_comb begin
        acc_diff = acc - {1'b0, dsr};
        if (acc >= {1'b0, dsr}) begin
            {acc_next, quo_next} = {acc_diff[width-1:0], quo, 1'b1};
        end else begin
            {acc_next, quo_next} = {acc, quo} << 1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            valid <= 1'b0;
            step  <= '0;
        end else begin
            valid <= 1'b0;                  // single cycle pulse
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == last_step) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end else begin
                    step <= step + cnt_w'(1);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            dsr        <= divisor;
            {acc, quo} <= {{width{1'b0}}, dividend, 1'b0};
        end else if (busy) begin
            acc <= acc_next;
            quo <= quo_next;
            if (step == last_step) begin
                quotient  <= quo_next;
                remainder <= acc_next[width:1];  // drop the last shift
            end
        end
    end

endmodule

/* verilog/div_lane.sv */
`timescale 1ns/1ps

module div_lane (
    input  logic              clk_i,
    input  logic              arst_n,
    input  logic              start,
    input  div_pkg::div_req_t req,
    input  logic              take,
    output logic              busy,
    output logic              done,
    output div_pkg::div_res_t res
);

    localparam int xlen = div_pkg::xlen;

    div_pkg::lane_state_e state;
    div_pkg::div_op_e     op_q;

    logic            neg_quo;              // operand signs differ
    logic            neg_rem;              // dividend was negative
    logic            req_signed;
    logic            req_rem;
    logic            div_zero;
    logic            div_ovf;
    logic [xlen-1:0] a_mag;
    logic [xlen-1:0] b_mag;
    logic            core_start;
    logic            core_valid;
    logic [xlen-1:0] core_quo;
    logic [xlen-1:0] core_rem;
    logic [xlen-1:0] quo_fix;
    logic [xlen-1:0] rem_fix;

    assign req_signed = (req.op == div_pkg::op_div) || (req.op == div_pkg::op_rem);
    assign req_rem    = (req.op == div_pkg::op_rem) || (req.op == div_pkg::op_remu);
    assign div_zero   = (req.b == '0);
    assign div_ovf    = req_signed && (req.a == {1'b1, {(xlen-1){1'b0}}}) && (req.b == '1);

    // the core only ever sees magnitudes
    assign a_mag = (req_signed && req.a[xlen-1]) ? -req.a : req.a;
    assign b_mag = (req_signed && req.b[xlen-1]) ? -req.b : req.b;

    assign core_start = start && (state == div_pkg::st_idle) && !div_zero && !div_ovf;

    assign quo_fix = neg_quo ? -core_quo : core_quo;
    assign rem_fix = neg_rem ? -core_rem : core_rem;

    assign busy = (state != div_pkg::st_idle);
    assign done = (state == div_pkg::st_done);

    div_core #(
        .width (xlen)
    ) i_div_core (
        .clk_i     (clk_i),
        .arst_n    (arst_n),
        .start     (core_start),
        .dividend  (a_mag),
        .divisor   (b_mag),
        .busy      (),
        .valid     (core_valid),
        .quotient  (core_quo),
        .remainder (core_rem)
    );

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            state <= div_pkg::st_idle;
        end else begin
            case (state)
                div_pkg::st_idle: if (start) state <= core_start ? div_pkg::st_run
                                                                 : div_pkg::st_done;
                div_pkg::st_run:  if (core_valid) state <= div_pkg::st_fix;
                div_pkg::st_fix:  state <= div_pkg::st_done;
                div_pkg::st_done: if (take) state <= div_pkg::st_idle;
                default:          state <= div_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start && (state == div_pkg::st_idle)) begin
            op_q    <= req.op;
            neg_quo <= req_signed && (req.a[xlen-1] ^ req.b[xlen-1]);
            neg_rem <= req_signed && req.a[xlen-1];
            res.tag <= req.tag;
            if (div_zero) begin
                res.value <= req_rem ? req.a : '1;       // RISC-V divide by zero
            end else if (div_ovf) begin
                res.value <= req_rem ? '0 : req.a;       // most negative / -1
            end
        end else if (state == div_pkg::st_fix) begin
            if ((op_q == div_pkg::op_rem) || (op_q == div_pkg::op_remu)) begin
                res.value <= rem_fix;
            end else begin
                res.value <= quo_fix;
            end
        end
    end

endmodule

/* verilog/div_dispatch.sv */
`timescale 1ns/1ps

module div_dispatch #(
    parameter int n_lanes = 4
) (
    input  logic               clk_i,
    input  logic               arst_n,
    input  logic               req_valid,
    input  div_pkg::div_req_t  req,
    input  logic [n_lanes-1:0] lane_busy,
    input  logic               lane_freed,
    output logic [n_lanes-1:0] lane_start,
    output div_pkg::div_req_t  lane_req,
    output logic               req_credit
);

    logic [n_lanes-1:0] lane_free;
    logic [n_lanes-1:0] pick;

    // a lane being started this cycle does not show busy yet
    assign lane_free = ~lane_busy & ~lane_start;

    // isolate the lowest set bit
    assign pick = lane_free & (-lane_free);

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            lane_start <= '0;
            req_credit <= 1'b0;
        end else begin
            lane_start <= req_valid ? pick : '0;
            req_credit <= lane_freed;        // credit back one cycle after take
        end
    end

    // broadcast to all lanes, only the started one captures
    always_ff @(posedge clk_i) begin
        if (req_valid) begin
            lane_req <= req;
        end
    end

endmodule

/* verilog/div_collect.sv */
`timescale 1ns/1ps

module div_collect #(
    parameter int n_lanes     = 4,
    parameter int res_credits = 2
) (
    input  logic                                clk_i,
    input  logic                                arst_n,
    input  logic              [n_lanes-1:0]     lane_done,
    input  div_pkg::div_res_t [n_lanes-1:0]     lane_res,
    input  logic                                res_credit,
    output logic              [n_lanes-1:0]     lane_take,
    output logic                                lane_freed,
    output logic                                res_valid,
    output div_pkg::div_res_t                   res
);

    localparam int ptr_w = (n_lanes > 1) ? $clog2(n_lanes) : 1;
    localparam int cnt_w = $clog2(res_credits + 1);

    logic [cnt_w-1:0] credit_cnt;
    logic [ptr_w-1:0] rr_ptr;
    logic [ptr_w-1:0] sel;
    logic             found;
    logic             take_any;

    // first done lane at or after the pointer
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int k = 0; k < n_lanes; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= n_lanes) begin
                idx = idx - n_lanes;
            end
            if (!found && lane_done[idx]) begin
                found = 1'b1;
                sel   = ptr_w'(idx);
            end
        end
    end

    assign take_any   = found && (credit_cnt != '0);
    assign lane_freed = take_any;

    always_comb begin
        for (int i = 0; i < n_lanes; i++) begin
            lane_take[i] = take_any && (sel == ptr_w'(i));
        end
    end

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= cnt_w'(res_credits);
            rr_ptr     <= '0;
            res_valid  <= 1'b0;
        end else begin
            res_valid <= take_any;
            if (take_any) begin
                rr_ptr <= (sel == ptr_w'(n_lanes - 1)) ? '0 : sel + ptr_w'(1);
            end
            case ({take_any, res_credit})
                2'b10:   credit_cnt <= credit_cnt - cnt_w'(1);
                2'b01:   credit_cnt <= credit_cnt + cnt_w'(1);
                default: credit_cnt <= credit_cnt;  // none or both
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_any) begin
            res <= lane_res[sel];
        end
    end

endmodule

/* verilog/div_unit.sv */
`timescale 1ns/1ps

module div_unit #(
    parameter int n_lanes     = 4,
    parameter int res_credits = 2
) (
    input  logic              clk_i,
    input  logic              arst_n,
    input  logic              req_valid,
    input  div_pkg::div_req_t req,
    output logic              req_credit,
    input  logic              res_credit,
    output logic              res_valid,
    output div_pkg::div_res_t res
);

    logic              [n_lanes-1:0] lane_start;
    logic              [n_lanes-1:0] lane_busy;
    logic              [n_lanes-1:0] lane_done;
    logic              [n_lanes-1:0] lane_take;
    div_pkg::div_res_t [n_lanes-1:0] lane_res;
    div_pkg::div_req_t               lane_req;
    logic                            lane_freed;

    div_dispatch #(
        .n_lanes (n_lanes)
    ) i_div_dispatch (
        .clk_i      (clk_i),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .lane_busy  (lane_busy),
        .lane_freed (lane_freed),
        .lane_start (lane_start),
        .lane_req   (lane_req),
        .req_credit (req_credit)
    );

    for (genvar g = 0; g < n_lanes; g++) begin : g_lane
        div_lane i_div_lane (
            .clk_i  (clk_i),
            .arst_n (arst_n),
            .start  (lane_start[g]),
            .req    (lane_req),
            .take   (lane_take[g]),
            .busy   (lane_busy[g]),
            .done   (lane_done[g]),
            .res    (lane_res[g])
        );
    end

    div_collect #(
        .n_lanes     (n_lanes),
        .res_credits (res_credits)
    ) i_div_collect (
        .clk_i      (clk_i),
        .arst_n     (arst_n),
        .lane_done  (lane_done),
        .lane_res   (lane_res),
        .res_credit (res_credit),
        .lane_take  (lane_take),
        .lane_freed (lane_freed),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

/* bench/div_unit_tb.sv */
`timescale 1ns/1ps

module div_unit_tb;

    localparam int n_lanes      = 4;
    localparam int res_credits  = 2;
    localparam int tag_w        = div_pkg::tag_w;
    localparam int n_tags       = 1 << tag_w;
    localparam int credit_limit = 400;   // cycles to wait for a request credit
    localparam int drain_limit  = 2000;
    localparam int unsigned seed = 15088;

    logic              clk_i;
    logic              arst_n;
    logic              req_valid;
    div_pkg::div_req_t req;
    logic              req_credit;
    logic              res_credit = 1'b0;
    logic              res_valid;
    div_pkg::div_res_t res;

    div_pkg::div_res_t exp_res [n_tags];   // expected result by tag
    int                sent_count [n_tags];
    int                seen_count [n_tags];
    int                requests_sent = 0;
    int                credits_returned = 0;
    int                results_seen = 0;
    int                res_granted = 0;
    logic              hold_results;
    int                base;
    int                cycles;

    div_unit #(
        .n_lanes     (n_lanes),
        .res_credits (res_credits)
    ) i_div_unit (
        .clk_i      (clk_i),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_res(input div_pkg::div_res_t got, input div_pkg::div_res_t want);
        if (got !== want) begin
            stop_on_error($sformatf("error at %0t: tag %0d value %h, expected tag %0d value %h",
                                    $time, got.tag, got.value, want.tag, want.value));
        end
    endtask

    task automatic check_credit(input string what, input int got, input int want);
        if (got != want) begin
            stop_on_error($sformatf("error at %0t: %s is %0d, expected %0d",
                                    $time, what, got, want));
        end
    endtask

    // RISC-V M extension divide rules
    function automatic logic [31:0] div_ref(input div_pkg::div_req_t r);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        logic               ovf;
        sa  = r.a;
        sb  = r.b;
        sq  = '0;
        sr  = '0;
        ovf = (r.a == 32'h8000_0000) && (r.b == 32'hffff_ffff);
        if ((r.b != '0) && !ovf) begin
            sq = sa / sb;                // truncates toward zero
            sr = sa % sb;                // sign of the dividend
        end
        case (r.op)
            div_pkg::op_divu: return (r.b == '0) ? '1 : r.a / r.b;
            div_pkg::op_remu: return (r.b == '0) ? r.a : r.a % r.b;
            div_pkg::op_div:  return (r.b == '0) ? '1 : (ovf ? r.a : sq);
            default:          return (r.b == '0) ? r.a : (ovf ? '0 : sr);
        endcase
    endfunction

    // wide spread of magnitudes, small ones included
    function automatic logic [31:0] rand_operand();
        return $urandom >> ($urandom % 32);
    endfunction

    task automatic send_req(input div_pkg::div_op_e op, input logic [31:0] a,
                            input logic [31:0] b);
        div_pkg::div_req_t r;
        int                wait_cnt;
        int                slot;
        wait_cnt = 0;
        while (n_lanes + credits_returned - requests_sent <= 0) begin  // out of credits
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > credit_limit) stop_on_error("timeout waiting for a request credit");
        end
        slot  = requests_sent % n_tags;    // at most n_lanes in flight, so tags stay unique
        r.op  = op;
        r.a   = a;
        r.b   = b;
        r.tag = tag_w'(slot);
        exp_res[slot].value = div_ref(r);
        exp_res[slot].tag   = r.tag;
        sent_count[slot]++;
        requests_sent++;
        req       = r;
        req_valid = 1'b1;
        @(negedge clk_i);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int wait_cnt;
        wait_cnt = 0;
        while ((results_seen != requests_sent) || (res_granted != results_seen)) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > drain_limit) stop_on_error("timeout waiting for results to drain");
        end
    endtask

    // scoreboard, sampled on the rising edge
    always @(posedge clk_i) begin
        if (arst_n) begin
            if (req_credit) begin
                credits_returned++;
                if (credits_returned > requests_sent) begin
                    stop_on_error("request credit returned with no request outstanding");
                end
            end
            if (res_valid) begin
                results_seen++;
                if (results_seen > res_credits + res_granted) begin
                    stop_on_error("result sent without a result credit");
                end
                if (seen_count[res.tag] >= sent_count[res.tag]) begin
                    stop_on_error($sformatf("result for tag %0d which is not outstanding", res.tag));
                end
                seen_count[res.tag]++;
                check_res(res, exp_res[res.tag]);
            end
        end
    end

    // consumer gives one result credit back per result unless held
    always @(negedge clk_i) begin
        if (!hold_results && (res_granted < results_seen)) begin
            res_credit = 1'b1;
            res_granted++;
        end else begin
            res_credit = 1'b0;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        hold_results = 1'b0;
        for (int i = 0; i < n_tags; i++) begin
            sent_count[i] = 0;
            seen_count[i] = 0;
            exp_res[i]    = '0;
        end
        void'($urandom(seed));
        repeat (4) @(negedge clk_i);
        arst_n = 1'b1;
        @(negedge clk_i);

        repeat (40) begin                  // unsigned ops
            send_req(($urandom % 2) ? div_pkg::op_remu : div_pkg::op_divu, $urandom, rand_operand());
        end
        for (int s = 0; s < 4; s++) begin  // each sign combination
            a = rand_operand();
            b = rand_operand() | 32'd1;
            if (s[0]) a = -a;
            if (s[1]) b = -b;
            send_req(div_pkg::op_div, a, b);
            send_req(div_pkg::op_rem, a, b);
        end
        repeat (60) begin
            a = rand_operand();
            b = rand_operand();
            if ($urandom % 2) a = -a;
            if ($urandom % 2) b = -b;
            send_req(($urandom % 2) ? div_pkg::op_rem : div_pkg::op_div, a, b);
        end
        send_req(div_pkg::op_div, $urandom, '0);
        send_req(div_pkg::op_divu, $urandom, '0);
        send_req(div_pkg::op_rem, $urandom, '0);
        send_req(div_pkg::op_remu, $urandom, '0);
        send_req(div_pkg::op_div, 32'h8000_0000, '1);
        send_req(div_pkg::op_rem, 32'h8000_0000, '1);
        send_req(div_pkg::op_divu, 32'h8000_0000, '1);  // not an overflow when unsigned
        send_req(div_pkg::op_remu, 32'h8000_0000, '1);
        wait_drain();

        // result back-pressure, fill all lanes with credits withheld
        hold_results = 1'b1;
        base = results_seen;
        for (int i = 0; i < n_lanes; i++) begin
            send_req(div_pkg::div_op_e'(i % 4), $urandom, rand_operand());
        end
        cycles = 0;
        while (results_seen - base < res_credits) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > drain_limit) stop_on_error("timeout waiting for credited results");
        end
        repeat (60) @(negedge clk_i);      // finished lanes must keep holding
        check_credit("results while held", results_seen - base, res_credits);
        check_credit("request credits while held", n_lanes + credits_returned - requests_sent,
                     res_credits);
        hold_results = 1'b0;
        wait_drain();

        check_credit("request credits after drain", n_lanes + credits_returned - requests_sent,
                     n_lanes);
        $display("Test passed");
        $finish;
    end

endmodule

/* src.f */
verilog/div_pkg.sv
verilog/div_core.sv
verilog/div_lane.sv
verilog/div_dispatch.sv
verilog/div_collect.sv
verilog/div_unit.sv
bench/div_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module div_unit_tb

out=$(./obj_dir/Vdiv_unit_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1
